// ==== tb.f ====
bridgePkg.sv
spiFrameRx.sv
accessSequencer.sv
targetPort.sv
sdoShifter.sv
spiTargetBridge.sv
bridgeProperties_properties.sv
tb_spiTargetBridge.sv

// ==== tb_spiTargetBridge.sv ====
`timescale 1ns/1ps

module tb_spiTargetBridge;

  typedef struct {
    string                             name;
    bridgePkg::opcode_t                op;
    logic [bridgePkg::IndexWidth-1:0]  index;
    logic [bridgePkg::WordWidth-1:0]   start;
    int                                slots;
    int                                abortCycle;
  } frameRow_t;

  typedef struct packed {
    logic [1:0]                      target;
    logic                            isWrite;
    logic [bridgePkg::WordWidth-1:0] addr;
    logic [bridgePkg::WordWidth-1:0] data;
  } logEntry_t;

  logic               sclk;
  logic               sen;
  logic               sdi;
  logic               sdo;
  bridgePkg::busRsp_t targetRsp [bridgePkg::NumTargets];
  bridgePkg::busReq_t targetReq [bridgePkg::NumTargets];

  logic [31:0] lfsrState = 32'h6b41_540d;
  logic [31:0] modelKey [bridgePkg::NumTargets] = '{32'hA5A5_0000, 32'h5A5A_1111, 32'h0F0F_2222};
  logic        rspWait [bridgePkg::NumTargets];
  logic [31:0] rspAddr [bridgePkg::NumTargets];

  frameRow_t   frames [6];
  logic [31:0] frameWords [$];
  logic        sdoQ [$];
  logEntry_t   reqLog [$];
  int          cycleCount;
  int          cycleLimit;

  spiTargetBridge u_dut (
    .sclk      (sclk),
    .sen       (sen),
    .sdi       (sdi),
    .targetRsp (targetRsp),
    .sdo       (sdo),
    .targetReq (targetReq)
  );

  initial sclk = 1'b0;
  always #4 sclk = ~sclk;

  // --------------------
  // target models
  // --------------------
  // log every request and answer each read two edges after it was seen
  always @(posedge sclk) begin
    logEntry_t   entry;
    logic        fire [bridgePkg::NumTargets];
    logic [31:0] fireData [bridgePkg::NumTargets];
    for (int t = 0; t < bridgePkg::NumTargets; t++) begin
      fire[t]     = rspWait[t];
      fireData[t] = rspAddr[t] ^ modelKey[t];
      rspWait[t]  = 1'b0;
      if (targetReq[t].write || targetReq[t].read) begin
        entry.target  = 2'(t);
        entry.isWrite = targetReq[t].write;
        entry.addr    = targetReq[t].addr;
        entry.data    = targetReq[t].write ? targetReq[t].data : '0;
        reqLog.push_back(entry);
      end
      if (targetReq[t].read) begin
        rspWait[t] = 1'b1;
        rspAddr[t] = targetReq[t].addr;
      end
    end
    #1;
    for (int t = 0; t < bridgePkg::NumTargets; t++) begin
      targetRsp[t].resp = fire[t];
      targetRsp[t].data = fire[t] ? fireData[t] : '0;
    end
  end

  always @(posedge sclk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("timeout: run went past %0d clock cycles", cycleLimit);
      $display("Something failed");
      $fatal(1, "simulation stopped by cycle limit");
    end
  end

  // --------------------
  // helpers
  // --------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsrWord();
    logic [31:0] w;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsrBit()};
    end
    return w;
  endfunction

  function automatic int headerLen();
    return bridgePkg::CmdWidth + bridgePkg::WordWidth;
  endfunction

  // one trailing cycle lets the last request leave before sen rises
  function automatic int frameCycles(frameRow_t row);
    if (row.abortCycle != 0) begin
      return row.abortCycle;
    end
    return headerLen() + bridgePkg::WordWidth * row.slots + 1;
  endfunction

  // serial bit sampled at frame cycle k
  function automatic logic frameBit(int k, logic [7:0] cmdByte, logic [31:0] startAddr);
    int slot;
    slot = (k - headerLen()) / bridgePkg::WordWidth;
    if (k < bridgePkg::CmdWidth) begin
      return cmdByte[bridgePkg::CmdWidth-1-k];
    end
    if (k < headerLen()) begin
      return startAddr[headerLen()-1-k];
    end
    if (slot >= frameWords.size()) begin
      return 1'b0;
    end
    return frameWords[slot][31 - (k - headerLen()) % bridgePkg::WordWidth];
  endfunction

  task automatic checkValue(input string name, input logic [65:0] expected,
                            input logic [65:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // sen held high so nothing may reach the targets or sdo
  task automatic idleCycles(input int count, input string where);
    repeat (count) begin
      @(posedge sclk);
      for (int t = 0; t < bridgePkg::NumTargets; t++) begin
        checkValue($sformatf("%s idle req %0d", where, t), '0, targetReq[t]);
      end
      checkValue({where, " idle sdo"}, '0, sdo);
      #1;
    end
  endtask

  task automatic checkLog(input frameRow_t row, input int nCycles);
    logEntry_t expQ [$];
    logEntry_t e;
    e.target = 2'(row.index);
    e.data   = '0;
    if (row.index < bridgePkg::NumTargets) begin
      for (int n = 0; n < row.slots; n++) begin
        e.addr = row.start + bridgePkg::AddrStep * n;
        if (row.op == bridgePkg::opWrite) begin
          // write seen one edge after the last bit of its word
          e.isWrite = 1'b1;
          e.data    = frameWords[n];
          if (headerLen() + bridgePkg::WordWidth * (n + 1) < nCycles) begin
            expQ.push_back(e);
          end
        end else if (headerLen() + bridgePkg::WordWidth * n + 1 < nCycles) begin
          e.isWrite = 1'b0;
          expQ.push_back(e);
        end
      end
    end
    checkValue({row.name, " request count"}, expQ.size(), reqLog.size());
    foreach (expQ[i]) begin
      checkValue($sformatf("%s target %0d", row.name, i), expQ[i].target, reqLog[i].target);
      checkValue($sformatf("%s kind %0d", row.name, i), expQ[i].isWrite, reqLog[i].isWrite);
      checkValue($sformatf("%s addr %0d", row.name, i), expQ[i].addr, reqLog[i].addr);
      checkValue($sformatf("%s data %0d", row.name, i), expQ[i].data, reqLog[i].data);
    end
  endtask

  task automatic checkSdo(input frameRow_t row, input int nCycles);
    int          base;
    logic [31:0] got;
    logic [31:0] want;
    for (int k = 0; k < headerLen(); k++) begin
      checkValue($sformatf("%s sdo cycle %0d", row.name, k), '0, sdoQ[k]);
    end
    for (int n = 0; n < row.slots; n++) begin
      base = headerLen() + bridgePkg::WordWidth * n;
      if (base + bridgePkg::WordWidth <= nCycles) begin
        for (int i = 0; i < 32; i++) begin
          got = {got[30:0], sdoQ[base + i]};
        end
        want = '0;
        // slot n shows the word read in slot n-1
        if (row.op == bridgePkg::opRead && row.index < bridgePkg::NumTargets && n > 0) begin
          want = (row.start + bridgePkg::AddrStep * (n - 1)) ^ modelKey[row.index];
        end
        checkValue($sformatf("%s sdo slot %0d", row.name, n), want, got);
      end
    end
  endtask

  task automatic runFrame(input frameRow_t row);
    logic [7:0] cmdByte;
    int         nCycles;
    cmdByte = {row.index, row.op};
    nCycles = frameCycles(row);
    frameWords.delete();
    sdoQ.delete();
    reqLog.delete();
    if (row.op == bridgePkg::opWrite) begin
      for (int n = 0; n < row.slots; n++) begin
        frameWords.push_back(lfsrWord());
      end
    end
    sen = 1'b0;
    sdi = frameBit(0, cmdByte, row.start);
    for (int k = 0; k < nCycles; k++) begin
      @(posedge sclk);
      sdoQ.push_back(sdo);
      #1;
      sdi = frameBit(k + 1, cmdByte, row.start);
    end
    sen = 1'b1;
    sdi = 1'b0;
    idleCycles(2, row.name);
    checkLog(row, nCycles);
    checkSdo(row, nCycles);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int total;
    sen = 1'b0;
    sdi = 1'b0;
    cycleCount = 0;
    for (int t = 0; t < bridgePkg::NumTargets; t++) begin
      targetRsp[t] = '0;
      rspWait[t]   = 1'b0;
      rspAddr[t]   = '0;
    end

    frames[0] = '{"writeBurst", bridgePkg::opWrite, 7'd1, 32'h0000_1000, 3, 0};
    frames[1] = '{"readBurst", bridgePkg::opRead, 7'd2, 32'h0000_2040, 4, 0};
    frames[2] = '{"writeOutOfRange", bridgePkg::opWrite, 7'd5, 32'h0000_3000, 2, 0};
    frames[3] = '{"readOutOfRange", bridgePkg::opRead, 7'd5, 32'h0000_3100, 2, 0};
    // sen rises halfway through slot 2
    frames[4] = '{"abortedWrite", bridgePkg::opWrite, 7'd1, 32'h0000_4000, 3, 120};
    frames[5] = '{"writeAfterIdle", bridgePkg::opWrite, 7'd0, 32'h0000_0200, 2, 0};

    total = 3;
    foreach (frames[i]) begin
      total += frameCycles(frames[i]) + 2;
    end
    cycleLimit = (total * 3) / 2;

    #1;
    sen = 1'b1;
    idleCycles(3, "reset");
    foreach (frames[i]) begin
      runFrame(frames[i]);
    end

    if (u_dut.uProps.failCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== bridgeProperties_properties.sv ====
`timescale 1ns/1ps

module bridgeProperties (
  input logic               sclk,
  input logic               sen,
  input bridgePkg::busReq_t targetReq [bridgePkg::NumTargets]
);

  logic [bridgePkg::NumTargets-1:0] active;
  logic [bridgePkg::NumTargets-1:0] bothSet;
  int failCount = 0;

  always_comb begin
    for (int t = 0; t < bridgePkg::NumTargets; t++) begin
      active[t]  = targetReq[t].write | targetReq[t].read;
      bothSet[t] = targetReq[t].write & targetReq[t].read;
    end
  end

  // --------------------
  // request rules
  // --------------------
  oneTarget: assert property (@(posedge sclk) disable iff (sen) $onehot0(active))
    else begin
      failCount++;
      $error("more than one target request in the same cycle");
    end

  noWriteAndRead: assert property (@(posedge sclk) disable iff (sen) bothSet == '0)
    else begin
      failCount++;
      $error("write and read high together on one target");
    end

  // sen is the reset, so the bus must be quiet
  quietInReset: assert property (@(posedge sclk) sen |-> active == '0)
    else begin
      failCount++;
      $error("target request while sen is high");
    end

endmodule

bind spiTargetBridge bridgeProperties uProps (
  .sclk      (sclk),
  .sen       (sen),
  .targetReq (targetReq)
);

// ==== spiTargetBridge.sv ====
`timescale 1ns/1ps

module spiTargetBridge (
  input  logic               sclk,
  input  logic               sen,
  input  logic               sdi,
  input  bridgePkg::busRsp_t targetRsp [bridgePkg::NumTargets],
  output logic               sdo,
  output bridgePkg::busReq_t targetReq [bridgePkg::NumTargets]
);

  bridgePkg::wordEvent_t           evt;
  bridgePkg::command_t             cmd;
  bridgePkg::busReq_t              req;
  bridgePkg::busRsp_t              rsp;
  logic [bridgePkg::IndexWidth-1:0] index;
  logic [bridgePkg::WordWidth-1:0]  readWord;
  logic                             loadPulse;

  // --------------------
  // serial input side
  // --------------------
  spiFrameRx uFrameRx (
    .sclk (sclk),
    .sen  (sen),
    .sdi  (sdi),
    .evt  (evt),
    .cmd  (cmd)
  );

  accessSequencer uSequencer (
    .sclk      (sclk),
    .sen       (sen),
    .evt       (evt),
    .cmd       (cmd),
    .rsp       (rsp),
    .req       (req),
    .index     (index),
    .readWord  (readWord),
    .loadPulse (loadPulse)
  );

  // --------------------
  // target and sdo side
  // --------------------
  targetPort uTargetPort (
    .index     (index),
    .req       (req),
    .targetRsp (targetRsp),
    .targetReq (targetReq),
    .rsp       (rsp)
  );

  sdoShifter uSdoShifter (
    .sclk      (sclk),
    .sen       (sen),
    .loadPulse (loadPulse),
    .readWord  (readWord),
    .sdo       (sdo)
  );

endmodule

// ==== sdoShifter.sv ====
`timescale 1ns/1ps

module sdoShifter (
  input  logic                            sclk,
  input  logic                            sen,
  input  logic                            loadPulse,
  input  logic [bridgePkg::WordWidth-1:0] readWord,
  output logic                            sdo
);

  logic [bridgePkg::WordWidth-1:0] shiftReg;

  // MSB goes straight out while loading, the rest follows one per edge
  assign sdo = loadPulse ? readWord[bridgePkg::WordWidth-1]
                         : shiftReg[bridgePkg::WordWidth-1];

  // zeros shift in behind the word, so the line idles low
  always_ff @(posedge sclk or posedge sen) begin
    if (sen) begin
      shiftReg <= '0;
    end else if (loadPulse) begin
      shiftReg <= {readWord[bridgePkg::WordWidth-2:0], 1'b0};
    end else begin
      shiftReg <= {shiftReg[bridgePkg::WordWidth-2:0], 1'b0};
    end
  end

endmodule

// ==== targetPort.sv ====
`timescale 1ns/1ps

module targetPort (
  input  logic [bridgePkg::IndexWidth-1:0] index,
  input  bridgePkg::busReq_t               req,
  input  bridgePkg::busRsp_t               targetRsp [bridgePkg::NumTargets],
  output bridgePkg::busReq_t               targetReq [bridgePkg::NumTargets],
  output bridgePkg::busRsp_t               rsp
);

  // --------------------
  // request fan-out
  // --------------------
  // only the addressed target sees anything, the rest stay at zero
  always_comb begin
    for (int t = 0; t < bridgePkg::NumTargets; t++) begin
      if (index == bridgePkg::IndexWidth'(t)) begin
        targetReq[t] = req;
      end else begin
        targetReq[t] = '0;
      end
    end
  end

  // --------------------
  // response merge
  // --------------------
  // walk downward so the lowest index wins
  always_comb begin
    rsp = '0;
    for (int t = bridgePkg::NumTargets - 1; t >= 0; t--) begin
      if (targetRsp[t].resp) begin
        rsp = targetRsp[t];
      end
    end
  end

endmodule

// ==== accessSequencer.sv ====
`timescale 1ns/1ps

module accessSequencer (
  input  logic                                 sclk,
  input  logic                                 sen,
  input  bridgePkg::wordEvent_t                evt,
  input  bridgePkg::command_t                  cmd,
  input  bridgePkg::busRsp_t                   rsp,
  output bridgePkg::busReq_t                   req,
  output logic [bridgePkg::IndexWidth-1:0]     index,
  output logic [bridgePkg::WordWidth-1:0]      readWord,
  output logic                                 loadPulse
);

  logic [bridgePkg::WordWidth-1:0] wordAddr;
  logic [bridgePkg::WordWidth-1:0] pendWord;

  logic inRange;
  logic isWrite;
  logic writeHit;
  logic readHit;

  // --------------------
  // request decode
  // --------------------
  // indexes past the last target never reach the bus
  assign inRange  = cmd.index < bridgePkg::IndexWidth'(bridgePkg::NumTargets);
  assign isWrite  = cmd.op == bridgePkg::opWrite;
  assign writeHit = evt.wordValid && isWrite && inRange;
  assign readHit  = evt.slotStart && !isWrite && inRange;

  assign index = cmd.index;

  // running word address, stepped after every issued request
  always_ff @(posedge sclk or posedge sen) begin
    if (sen) begin
      wordAddr <= '0;
    end else if (evt.addrValid) begin
      wordAddr <= evt.word;
    end else if (writeHit || readHit) begin
      wordAddr <= wordAddr + bridgePkg::WordWidth'(bridgePkg::AddrStep);
    end
  end

  // one-cycle request pulses, one cycle after the triggering event
  always_ff @(posedge sclk or posedge sen) begin
    if (sen) begin
      req <= '0;
    end else begin
      req.write <= writeHit;
      req.read  <= readHit;
      if (writeHit) begin
        req.addr <= wordAddr;
        req.data <= evt.word;
      end else if (readHit) begin
        req.addr <= wordAddr;
        req.data <= '0;
      end
    end
  end

  // --------------------
  // read data path
  // --------------------
  // word returned during slot n goes out in slot n+1
  assign loadPulse = evt.slotStart && !isWrite;
  assign readWord  = pendWord;

  // a response landing on slotStart already belongs to the new slot
  always_ff @(posedge sclk or posedge sen) begin
    if (sen) begin
      pendWord <= '0;
    end else if (rsp.resp && !isWrite) begin
      pendWord <= rsp.data;
    end else if (loadPulse) begin
      pendWord <= '0;
    end
  end

endmodule

// ==== spiFrameRx.sv ====
`timescale 1ns/1ps

module spiFrameRx (
  input  logic                  sclk,
  input  logic                  sen,
  input  logic                  sdi,
  output bridgePkg::wordEvent_t evt,
  output bridgePkg::command_t   cmd
);

  logic [bridgePkg::WordWidth-1:0] shiftReg;
  logic [bridgePkg::WordWidth-1:0] assembled;
  logic [bridgePkg::CntWidth-1:0]  bitCnt;
  bridgePkg::framePhase_t          phase;
  bridgePkg::command_t             cmdReg;

  logic cmdDone;
  logic addrDone;
  logic slotFirst;
  logic wordDone;
  logic partDone;

  // --------------------
  // event decode
  // --------------------
  // the bit on sdi right now is the one sampled at the next edge
  assign assembled = {shiftReg[bridgePkg::WordWidth-2:0], sdi};

  assign cmdDone   = (phase == bridgePkg::phCommand) &&
                     (bitCnt == bridgePkg::CntWidth'(bridgePkg::CmdWidth - 1));
  assign addrDone  = (phase == bridgePkg::phAddress) &&
                     (bitCnt == bridgePkg::CntWidth'(bridgePkg::WordWidth - 1));
  assign slotFirst = (phase == bridgePkg::phData) && (bitCnt == '0);
  assign wordDone  = (phase == bridgePkg::phData) &&
                     (bitCnt == bridgePkg::CntWidth'(bridgePkg::WordWidth - 1));
  assign partDone  = cmdDone | addrDone | wordDone;

  assign evt.cmdValid  = cmdDone;
  assign evt.addrValid = addrDone;
  assign evt.slotStart = slotFirst;
  assign evt.wordValid = wordDone;
  assign evt.word      = assembled;

  assign cmd = cmdReg;

  // --------------------
  // deserializer
  // --------------------
  // MSB first, so every new bit enters at the bottom
  always_ff @(posedge sclk or posedge sen) begin
    if (sen) begin
      shiftReg <= '0;
    end else begin
      shiftReg <= assembled;
    end
  end

  // bit counter and frame phase
  always_ff @(posedge sclk or posedge sen) begin
    if (sen) begin
      bitCnt <= '0;
      phase  <= bridgePkg::phCommand;
    end else begin
      if (partDone) begin
        bitCnt <= '0;
      end else begin
        bitCnt <= bitCnt + 1'b1;
      end
      case (phase)
        bridgePkg::phCommand: if (cmdDone)  phase <= bridgePkg::phAddress;
        bridgePkg::phAddress: if (addrDone) phase <= bridgePkg::phData;
        default:              phase <= bridgePkg::phData;
      endcase
    end
  end

  // command byte is index then op bit with the op bit last
  always_ff @(posedge sclk or posedge sen) begin
    if (sen) begin
      cmdReg <= '0;
    end else if (cmdDone) begin
      cmdReg.index <= assembled[bridgePkg::CmdWidth-1:1];
      cmdReg.op    <= bridgePkg::opcode_t'(sdi);
    end
  end

endmodule

// ==== bridgePkg.sv ====
package bridgePkg;

  // --------------------
  // widths and counts
  // --------------------
  localparam int WordWidth  = 32;
  localparam int CmdWidth   = 8;
  localparam int IndexWidth = 7;
  localparam int NumTargets = 3;
  localparam int AddrStep   = 4;

  // bit counter within one part of a frame
  localparam int CntWidth = $clog2(WordWidth);

  // --------------------
  // enums
  // --------------------
  typedef enum logic [0:0] {
    opRead  = 1'b0,
    opWrite = 1'b1
  } opcode_t;

  typedef enum logic [1:0] {
    phCommand = 2'd0,
    phAddress = 2'd1,
    phData    = 2'd2
  } framePhase_t;

  // --------------------
  // structs
  // --------------------
  // one word event from the serial side, all flags are single-cycle pulses
  typedef struct packed {
    logic                 cmdValid;
    logic                 addrValid;
    logic                 slotStart;
    logic                 wordValid;
    logic [WordWidth-1:0] word;
  } wordEvent_t;

  typedef struct packed {
    opcode_t               op;
    logic [IndexWidth-1:0] index;
  } command_t;

  typedef struct packed {
    logic                 write;
    logic                 read;
    logic [WordWidth-1:0] addr;
    logic [WordWidth-1:0] data;
  } busReq_t;

  typedef struct packed {
    logic                 resp;
    logic [WordWidth-1:0] data;
  } busRsp_t;

endpackage
